//--- source/trace_reg_pkg.sv
/* Trace sniffer register block definitions
   Address map, widths, reset values and shared bus and config types */

package trace_reg_pkg;

   ////////////////////////////////////////
   // Widths and fixed values
   ////////////////////////////////////////
   localparam int byte_w      = 8;
   localparam int bytecnt_w   = 7;
   localparam int match_rules = 8;
   localparam int buffer_w    = 64;        // Pattern and mask width

   localparam logic [1:0]          select_code = 2'd2;
   localparam logic [buffer_w-1:0] trace_name  = 64'h6563_6172_546d_7241; // "ArmTrace", byte 0 = 'A'
   localparam logic [byte_w-1:0]   trace_rev   = 8'h01;

   ////////////////////////////////////////
   // Register addresses (low 6 bits)
   ////////////////////////////////////////
   localparam logic [5:0] reg_name                = 6'd0;
   localparam logic [5:0] reg_rev                 = 6'd1;
   localparam logic [5:0] reg_pattern_enable      = 6'd2;
   localparam logic [5:0] reg_pattern_trig_enable = 6'd3;
   localparam logic [5:0] reg_trace_width         = 6'd4;
   localparam logic [5:0] reg_soft_trig_passthru  = 6'd5;
   localparam logic [5:0] reg_soft_trig_enable    = 6'd6;
   localparam logic [5:0] reg_capture_raw         = 6'd7;
   localparam logic [5:0] reg_record_syncs        = 6'd8;
   localparam logic [5:0] reg_synchronized        = 6'd9;
   localparam logic [5:0] reg_stat                = 6'd10;
   localparam logic [5:0] reg_trigger_freq        = 6'd11;
   localparam logic [5:0] reg_fe_freq             = 6'd12;
   localparam logic [5:0] reg_trace_count         = 6'd13;
   localparam logic [5:0] reg_pattern_base        = 6'd16; // Rules 0..7 at 16..23
   localparam logic [5:0] reg_mask_base           = 6'd24; // Rules 0..7 at 24..31
   localparam logic [5:0] reg_swo_enable          = 6'd32;
   localparam logic [5:0] reg_swo_bitrate_div     = 6'd33;
   localparam logic [5:0] reg_uart_stop_bits      = 6'd34;
   localparam logic [5:0] reg_uart_data_bits      = 6'd35;
   localparam logic [5:0] reg_uart_parity         = 6'd36;
   localparam logic [5:0] reg_trace_en            = 6'd37;
   localparam logic [5:0] reg_trace_reset_sync    = 6'd38;
   localparam logic [5:0] reg_traceclk_phase      = 6'd39;

   // Non-zero reset values
   localparam logic [2:0]          rst_trace_width        = 3'd4; // 4-lane trace
   localparam logic                rst_soft_trig_passthru = 1'b1;
   localparam logic                rst_soft_trig_enable   = 1'b1;
   localparam logic                rst_capture_raw        = 1'b1;
   localparam logic [15:0]         rst_swo_bitrate_div    = 16'd7;
   localparam logic [1:0]          rst_uart_stop_bits     = 2'd1;
   localparam logic [3:0]          rst_uart_data_bits     = 4'd8;
   localparam logic [buffer_w-1:0] rst_mask               = {buffer_w{1'b1}};

   ////////////////////////////////////////
   // Shared types
   ////////////////////////////////////////
   typedef struct packed {
      logic [7:0]           address;    // Top 2 bits pick the block
      logic [bytecnt_w-1:0] bytecnt;
      logic [byte_w-1:0]    write_data;
      logic                 read;       // Data due one cycle later
      logic                 write;
      logic                 addrvalid;
   } reg_bus_t;

   typedef struct packed {
      logic accept_errors;              // Bit 2
      logic parity_enabled;             // Bit 1
      logic parity_bit;                 // Bit 0
   } parity_fields_t;

   // Written and read as one raw word, consumed by the UART as flags
   typedef union packed {
      logic [2:0]     raw;
      parity_fields_t fields;
   } parity_cfg_u;

   typedef struct packed {
      logic [match_rules-1:0] pattern_enable;
      logic [match_rules-1:0] pattern_trig_enable;
      logic [2:0]             trace_width;
      logic                   soft_trig_passthru;
      logic                   soft_trig_enable;
      logic                   capture_raw;
      logic                   record_syncs;
      logic                   trace_en;
      logic                   swo_enable;
      logic [15:0]            swo_bitrate_div;
      logic [1:0]             uart_stop_bits;
      logic [3:0]             uart_data_bits;
      parity_cfg_u            uart_parity;
   } trace_cfg_t;

   typedef struct packed {
      logic        synchronized;
      logic        swo_cdc_overflow;
      logic [31:0] trigger_freq;
      logic [31:0] fe_freq;
      logic        phase_locked;
   } trace_status_t;

   typedef struct packed {
      logic [buffer_w-1:0] pattern;
      logic [buffer_w-1:0] mask;
   } rule_cfg_t;

endpackage

//--- source/reg_bus_decode.sv
/* Register bus decoder
   Block select, control write gate and one-hot rule byte strobes */

`timescale 1ns/1ns

module reg_bus_decode
   import trace_reg_pkg::*;
(
   input  reg_bus_t               bus,
   output logic                   selected,
   output logic                   ctrl_write,
   output logic [match_rules-1:0] pattern_write,
   output logic [match_rules-1:0] mask_write,
   output logic [2:0]             byte_lane
);

   logic [5:0] reg_addr;

   ////////////////////////////////////////
   // Block select
   ////////////////////////////////////////

   assign selected = bus.addrvalid && (bus.address[7:6] == select_code);
   assign reg_addr = bus.address[5:0];

   // Control regs compare the address themselves
   assign ctrl_write = selected && bus.write;

   // Byte position within a 64-bit pattern or mask
   assign byte_lane = bus.bytecnt[2:0];

   ////////////////////////////////////////
   // Rule strobes
   ////////////////////////////////////////

   always_comb begin
      pattern_write = '0;
      mask_write    = '0;
      for (int n = 0; n < match_rules; n++) begin
         // One strobe per rule slice
         pattern_write[n] = ctrl_write && (reg_addr == reg_pattern_base + 6'(n));
         mask_write[n]    = ctrl_write && (reg_addr == reg_mask_base + 6'(n));
      end
   end

endmodule

//--- source/match_rule_regs.sv
/* Match rule slice
   One 64-bit pattern and mask pair, written one byte lane at a time */

`timescale 1ns/1ns

module match_rule_regs
   import trace_reg_pkg::*;
(
   input  logic              usb_clk,
   input  logic              reset_i,
   input  logic              pattern_write,
   input  logic              mask_write,
   input  logic [2:0]        byte_lane,
   input  logic [byte_w-1:0] write_data,
   output rule_cfg_t         rule
);

   ////////////////////////////////////////
   // Pattern and mask storage
   ////////////////////////////////////////

   always_ff @(posedge usb_clk) begin
      if (reset_i) begin
         rule.pattern <= '0;
         rule.mask    <= rst_mask;           // Match nothing until set
      end else begin
         if (pattern_write) begin
            rule.pattern[byte_lane*byte_w +: byte_w] <= write_data;
         end
         if (mask_write) begin
            rule.mask[byte_lane*byte_w +: byte_w] <= write_data;
         end
      end
   end

   // Decoder must address pattern and mask banks disjointly
   a_strobe_exclusive: assert property (
      @(posedge usb_clk) disable iff (reset_i)
      !(pattern_write && mask_write)
   ) else $error("Pattern and mask strobes high together");

endmodule

//--- source/trace_ctrl_regs.sv
/* Capture and SWO/UART control registers
   Also makes the resync and phase load pulses and keeps the phase-done latch */

`timescale 1ns/1ns

module trace_ctrl_regs
   import trace_reg_pkg::*;
(
   input  logic        usb_clk,
   input  logic        reset_i,
   input  logic        ctrl_write,
   input  reg_bus_t    bus,
   input  logic        phase_done,
   output trace_cfg_t  cfg,
   output logic        reset_sync,
   output logic        phase_load,
   output logic [15:0] phase_requested,
   output logic        phase_done_latched
);

   logic [5:0] reg_addr;
   logic       byte_hi;          // Upper byte of 16-bit registers
   logic       resync_req;
   logic       resync_req_r;

   assign reg_addr = bus.address[5:0];
   assign byte_hi  = bus.bytecnt[0];

   ////////////////////////////////////////
   // Register writes
   ////////////////////////////////////////

   always_ff @(posedge usb_clk) begin
      if (reset_i) begin
         cfg.pattern_enable      <= '0;
         cfg.pattern_trig_enable <= '0;
         cfg.trace_width         <= rst_trace_width;
         cfg.soft_trig_passthru  <= rst_soft_trig_passthru;
         cfg.soft_trig_enable    <= rst_soft_trig_enable;
         cfg.capture_raw         <= rst_capture_raw;
         cfg.record_syncs        <= 1'b0;
         cfg.trace_en            <= 1'b0;
         cfg.swo_enable          <= 1'b0;
         cfg.swo_bitrate_div     <= rst_swo_bitrate_div;
         cfg.uart_stop_bits      <= rst_uart_stop_bits;
         cfg.uart_data_bits      <= rst_uart_data_bits;
         cfg.uart_parity.raw     <= 3'd0;  // Parity off
         phase_requested         <= '0;
      end else if (ctrl_write) begin
         case (reg_addr)
            reg_pattern_enable:      cfg.pattern_enable <= bus.write_data[match_rules-1:0];
            reg_pattern_trig_enable: cfg.pattern_trig_enable <= bus.write_data[match_rules-1:0];
            reg_trace_width:         cfg.trace_width <= bus.write_data[2:0];
            reg_soft_trig_passthru:  cfg.soft_trig_passthru <= bus.write_data[0];
            reg_soft_trig_enable:    cfg.soft_trig_enable <= bus.write_data[0];
            reg_capture_raw:         cfg.capture_raw <= bus.write_data[0];
            reg_record_syncs:        cfg.record_syncs <= bus.write_data[0];
            reg_trace_en:            cfg.trace_en <= bus.write_data[0];
            reg_swo_enable:          cfg.swo_enable <= bus.write_data[0];
            reg_swo_bitrate_div: begin
               cfg.swo_bitrate_div[byte_hi*byte_w +: byte_w] <= bus.write_data;
            end
            reg_uart_stop_bits:      cfg.uart_stop_bits <= bus.write_data[1:0];
            reg_uart_data_bits:      cfg.uart_data_bits <= bus.write_data[3:0];
            reg_uart_parity:         cfg.uart_parity.raw <= bus.write_data[2:0];
            reg_traceclk_phase: begin
               phase_requested[byte_hi*byte_w +: byte_w] <= bus.write_data;
            end
            default: ;
         endcase
      end
   end

   ////////////////////////////////////////
   // Pulses and phase-done latch
   ////////////////////////////////////////

   always_ff @(posedge usb_clk) begin
      if (reset_i) begin
         resync_req         <= 1'b0;
         resync_req_r       <= 1'b0;
         phase_load         <= 1'b0;
         phase_done_latched <= 1'b0;
      end else begin
         resync_req   <= ctrl_write && (reg_addr == reg_trace_reset_sync);
         resync_req_r <= resync_req;

         // Load fires on the high byte, after both bytes are in
         phase_load <= ctrl_write && (reg_addr == reg_traceclk_phase)
                       && (bus.bytecnt == bytecnt_w'(1));

         if (phase_load) begin
            phase_done_latched <= 1'b0;   // New request pending
         end else if (phase_done) begin
            phase_done_latched <= 1'b1;
         end
      end
   end

   assign reset_sync = resync_req & ~resync_req_r;   // Rising edge only

   a_resync_single: assert property (
      @(posedge usb_clk) disable iff (reset_i)
      reset_sync |=> !reset_sync
   ) else $error("reset_sync high for more than one cycle");

endmodule

//--- source/reg_read_mux.sv
/* Register read multiplexer
   Picks the addressed byte and registers it onto read_data */

`timescale 1ns/1ns

module reg_read_mux
   import trace_reg_pkg::*;
(
   input  logic                               usb_clk,
   input  reg_bus_t                           bus,
   input  logic                               selected,
   input  trace_cfg_t                         cfg,
   input  rule_cfg_t [match_rules-1:0]        rules,
   input  logic [match_rules-1:0][byte_w-1:0] trace_counts,
   input  trace_status_t                      status,
   input  logic                               phase_done_latched,
   output logic [byte_w-1:0]                  read_data
);

   logic [5:0]          reg_addr;
   logic [2:0]          lane8;      // Byte of a 64-bit value
   logic [1:0]          lane4;      // Byte of a 32-bit value
   logic                lane2;      // Byte of a 16-bit value
   logic [2:0]          rule_idx;
   logic [buffer_w-1:0] count_word;
   logic [byte_w-1:0]   read_next;

   assign reg_addr = bus.address[5:0];
   assign lane8    = bus.bytecnt[2:0];
   assign lane4    = bus.bytecnt[1:0];
   assign lane2    = bus.bytecnt[0];
   assign rule_idx = reg_addr[2:0];        // Rule banks are 8-aligned

   // Rule 0 count sits in the top byte
   always_comb begin
      count_word = '0;
      for (int n = 0; n < match_rules; n++) begin
         count_word[(match_rules-1-n)*byte_w +: byte_w] = trace_counts[n];
      end
   end

   ////////////////////////////////////////
   // Byte select
   ////////////////////////////////////////

   always_comb begin
      read_next = '0;
      if (selected && bus.read) begin
         case (reg_addr)
            reg_name:                read_next = trace_name[lane8*byte_w +: byte_w];
            reg_rev:                 read_next = trace_rev;
            reg_pattern_enable:      read_next = byte_w'(cfg.pattern_enable);
            reg_pattern_trig_enable: read_next = byte_w'(cfg.pattern_trig_enable);
            reg_trace_width:         read_next = byte_w'(cfg.trace_width);
            reg_soft_trig_passthru:  read_next = byte_w'(cfg.soft_trig_passthru);
            reg_soft_trig_enable:    read_next = byte_w'(cfg.soft_trig_enable);
            reg_capture_raw:         read_next = byte_w'(cfg.capture_raw);
            reg_record_syncs:        read_next = byte_w'(cfg.record_syncs);
            reg_synchronized:        read_next = byte_w'(status.synchronized);
            reg_stat:                read_next = byte_w'(status.swo_cdc_overflow);
            reg_trigger_freq:        read_next = status.trigger_freq[lane4*byte_w +: byte_w];
            reg_fe_freq:             read_next = status.fe_freq[lane4*byte_w +: byte_w];
            reg_trace_count:         read_next = count_word[lane8*byte_w +: byte_w];
            reg_swo_enable:          read_next = byte_w'(cfg.swo_enable);
            reg_swo_bitrate_div:     read_next = cfg.swo_bitrate_div[lane2*byte_w +: byte_w];
            reg_uart_stop_bits:      read_next = byte_w'(cfg.uart_stop_bits);
            reg_uart_data_bits:      read_next = byte_w'(cfg.uart_data_bits);
            reg_uart_parity:         read_next = byte_w'(cfg.uart_parity.raw);
            reg_trace_en:            read_next = byte_w'(cfg.trace_en);
            reg_traceclk_phase: begin
               read_next = {6'b0, status.phase_locked, phase_done_latched};
            end
            default: begin
               // Pattern and mask banks
               if (reg_addr[5:3] == reg_pattern_base[5:3]) begin
                  read_next = rules[rule_idx].pattern[lane8*byte_w +: byte_w];
               end else if (reg_addr[5:3] == reg_mask_base[5:3]) begin
                  read_next = rules[rule_idx].mask[lane8*byte_w +: byte_w];
               end
            end
         endcase
      end
   end

   ////////////////////////////////////////
   // Read stage
   ////////////////////////////////////////

   always_ff @(posedge usb_clk) begin
      read_data <= read_next;     // Valid the cycle after read
   end

endmodule

//--- source/reg_trace.sv
/* Trace sniffer register block top level
   Bus decoder, eight match rule slices, control registers and read path */

`timescale 1ns/1ns

module reg_trace
   import trace_reg_pkg::*;
(
   input  logic                               usb_clk,
   input  logic                               reset_i,
   input  reg_bus_t                           bus,
   input  trace_status_t                      status,
   input  logic [match_rules-1:0][byte_w-1:0] trace_counts,
   input  logic                               phase_done,
   output logic [byte_w-1:0]                  read_data,
   output logic                               selected,
   output trace_cfg_t                         cfg,
   output rule_cfg_t [match_rules-1:0]        rules,
   output logic                               reset_sync,
   output logic                               phase_load,
   output logic [15:0]                        phase_requested
);

   logic                   ctrl_write;
   logic [match_rules-1:0] pattern_write;
   logic [match_rules-1:0] mask_write;
   logic [2:0]             byte_lane;
   logic                   phase_done_latched;

   reg_bus_decode u_decode (
      .bus           (bus),
      .selected      (selected),
      .ctrl_write    (ctrl_write),
      .pattern_write (pattern_write),
      .mask_write    (mask_write),
      .byte_lane     (byte_lane)
   );

   ////////////////////////////////////////
   // Match rule slices
   ////////////////////////////////////////

   for (genvar n = 0; n < match_rules; n++) begin : g_rule
      match_rule_regs u_rule (
         .usb_clk       (usb_clk),
         .reset_i       (reset_i),
         .pattern_write (pattern_write[n]),
         .mask_write    (mask_write[n]),
         .byte_lane     (byte_lane),
         .write_data    (bus.write_data),
         .rule          (rules[n])
      );
   end

   trace_ctrl_regs u_ctrl (
      .usb_clk            (usb_clk),
      .reset_i            (reset_i),
      .ctrl_write         (ctrl_write),
      .bus                (bus),
      .phase_done         (phase_done),
      .cfg                (cfg),
      .reset_sync         (reset_sync),
      .phase_load         (phase_load),
      .phase_requested    (phase_requested),
      .phase_done_latched (phase_done_latched)
   );

   reg_read_mux u_read (
      .usb_clk            (usb_clk),
      .bus                (bus),
      .selected           (selected),
      .cfg                (cfg),
      .rules              (rules),
      .trace_counts       (trace_counts),
      .status             (status),
      .phase_done_latched (phase_done_latched),
      .read_data          (read_data)
   );

endmodule

//--- test/tb_reg_trace.sv
/* Trace sniffer register block testbench
   Shadow register model, bus read and write tasks, pulse checks and summary */

`timescale 1ns/1ns

module tb_reg_trace
   import trace_reg_pkg::*;
;
   localparam int watchdog_cycles = 20000;  // About ten times the test length

   localparam logic [5:0] ctrl_addrs [12] = '{
      reg_pattern_enable, reg_pattern_trig_enable, reg_trace_width, reg_soft_trig_passthru,
      reg_soft_trig_enable, reg_capture_raw, reg_record_syncs, reg_swo_enable,
      reg_uart_stop_bits, reg_uart_data_bits, reg_uart_parity, reg_trace_en
   };

   logic                               usb_clk = 1'b0;
   logic                               reset_i = 1'b1;
   reg_bus_t                           bus = '0;
   trace_status_t                      status = '0;
   logic [match_rules-1:0][byte_w-1:0] trace_counts = '0;
   logic                               phase_done = 1'b0;
   logic [byte_w-1:0]                  read_data;
   logic                               selected;
   trace_cfg_t                         cfg;
   rule_cfg_t [match_rules-1:0]        rules;
   logic                               reset_sync;
   logic                               phase_load;
   logic [15:0]                        phase_requested;

   logic [63:0] shadow [0:63];    // Register image by address
   logic [15:0] phase_model;
   logic        done_model;
   logic [16:0] exp_q [$];       // {addr, byte, expected}
   integer      seed = 29440;
   int          checks = 0;
   int          errors = 0;
   int          test_start = 0;

   always #4 usb_clk = ~usb_clk;

   reg_trace u_reg_trace (
      .usb_clk         (usb_clk),
      .reset_i         (reset_i),
      .bus             (bus),
      .status          (status),
      .trace_counts    (trace_counts),
      .phase_done      (phase_done),
      .read_data       (read_data),
      .selected        (selected),
      .cfg             (cfg),
      .rules           (rules),
      .reset_sync      (reset_sync),
      .phase_load      (phase_load),
      .phase_requested (phase_requested)
   );

   ////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////

   function automatic logic [7:0] write_mask(input logic [5:0] addr);
      case (addr)
         reg_pattern_enable, reg_pattern_trig_enable: return 8'hff;
         reg_trace_width, reg_uart_parity: return 8'h07;
         reg_soft_trig_passthru, reg_soft_trig_enable, reg_capture_raw, reg_record_syncs,
         reg_swo_enable, reg_trace_en: return 8'h01;
         reg_uart_stop_bits: return 8'h03;
         reg_uart_data_bits: return 8'h0f;
         default: return 8'h00;               // Read-only or unmapped
      endcase
   endfunction

   function automatic int reg_bytes(input logic [5:0] addr);
      if (addr == reg_name || addr == reg_trace_count || addr[5:4] == 2'b01) return 8;
      if (addr == reg_trigger_freq || addr == reg_fe_freq) return 4;
      if (addr == reg_swo_bitrate_div) return 2;
      return 1;
   endfunction

   function automatic logic [7:0] expected_byte(input logic [5:0] addr, input int bc);
      string name_str;
      name_str = "ArmTrace";
      case (addr)
         reg_name:           return name_str[bc];
         reg_rev:            return 8'd1;
         reg_synchronized:   return {7'd0, status.synchronized};
         reg_stat:           return {7'd0, status.swo_cdc_overflow};
         reg_trigger_freq:   return status.trigger_freq[bc*8 +: 8];
         reg_fe_freq:        return status.fe_freq[bc*8 +: 8];
         reg_trace_count:    return trace_counts[7-bc];   // Rule 0 in top byte
         reg_traceclk_phase: return {6'd0, status.phase_locked, done_model};
         default:            return shadow[addr][bc*8 +: 8];
      endcase
   endfunction

   task automatic reset_model();
      for (int a = 0; a < 64; a++) begin
         shadow[a] = '0;
      end
      shadow[reg_trace_width]        = 64'(rst_trace_width);
      shadow[reg_soft_trig_passthru] = 64'(rst_soft_trig_passthru);
      shadow[reg_soft_trig_enable]   = 64'(rst_soft_trig_enable);
      shadow[reg_capture_raw]        = 64'(rst_capture_raw);
      shadow[reg_swo_bitrate_div]    = 64'(rst_swo_bitrate_div);
      shadow[reg_uart_stop_bits]     = 64'(rst_uart_stop_bits);
      shadow[reg_uart_data_bits]     = 64'(rst_uart_data_bits);
      for (int n = 0; n < match_rules; n++) begin
         shadow[reg_mask_base + 6'(n)] = rst_mask;
      end
      phase_model = '0;
      done_model  = 1'b0;
   endtask

   task automatic model_write(input logic [5:0] addr, input int bc, input logic [7:0] data);
      if (addr[5:4] == 2'b01) begin
         shadow[addr][bc*8 +: 8] = data;           // Pattern and mask banks
      end else if (addr == reg_swo_bitrate_div) begin
         shadow[addr][(bc%2)*8 +: 8] = data;
      end else if (addr == reg_traceclk_phase) begin
         phase_model[(bc%2)*8 +: 8] = data;
      end else if (write_mask(addr) != 8'h00) begin
         shadow[addr] = {56'd0, data & write_mask(addr)};
      end
   endtask

   ////////////////////////////////////////
   // Bus tasks and checks
   ////////////////////////////////////////

   task automatic check_equal(input string what, input logic [63:0] got,
                              input logic [63:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic bus_write(input logic [1:0] sel, input logic valid, input logic [5:0] addr,
                            input int bc, input logic [7:0] data);
      logic hit;
      hit = (sel == select_code) && valid;
      @(posedge usb_clk);
      #1;
      bus.address    = {sel, addr};
      bus.bytecnt    = 7'(bc);
      bus.write_data = data;
      bus.write      = 1'b1;
      bus.addrvalid  = valid;
      @(posedge usb_clk);                        // Write edge
      check_equal("selected on write", 64'(selected), 64'(hit));
      #1;
      bus.write     = 1'b0;
      bus.addrvalid = 1'b0;
      if (hit) begin
         model_write(addr, bc, data);
      end
   endtask

   task automatic bus_read(input logic [1:0] sel, input logic valid, input logic [5:0] addr,
                           input int bc);
      logic [7:0] exp;
      logic       hit;
      hit = (sel == select_code) && valid;
      @(posedge usb_clk);
      #1;
      bus.address   = {sel, addr};
      bus.bytecnt   = 7'(bc);
      bus.read      = 1'b1;
      bus.addrvalid = valid;
      exp = hit ? expected_byte(addr, bc) : 8'd0;
      @(posedge usb_clk);
      check_equal("selected on read", 64'(selected), 64'(hit));
      #1;
      bus.read      = 1'b0;
      bus.addrvalid = 1'b0;
      exp_q.push_back({addr, 3'(bc), exp});      // Checked at the next falling edge
   endtask

   task automatic verify_range(input int lo, input int hi);
      for (int a = lo; a <= hi; a++) begin
         for (int bc = 0; bc < reg_bytes(6'(a)); bc++) begin
            bus_read(select_code, 1'b1, 6'(a), bc);
         end
      end
   endtask

   task automatic check_rules();
      for (int n = 0; n < match_rules; n++) begin
         check_equal($sformatf("rule %0d pattern", n), rules[n].pattern,
                     shadow[reg_pattern_base + 6'(n)]);
         check_equal($sformatf("rule %0d mask", n), rules[n].mask,
                     shadow[reg_mask_base + 6'(n)]);
      end
   endtask

   // Every cfg field against its register image
   task automatic check_cfg();
      check_equal("pattern enable", 64'(cfg.pattern_enable), shadow[reg_pattern_enable]);
      check_equal("pattern trigger enable", 64'(cfg.pattern_trig_enable),
                  shadow[reg_pattern_trig_enable]);
      check_equal("trace width", 64'(cfg.trace_width), shadow[reg_trace_width]);
      check_equal("soft trigger passthru", 64'(cfg.soft_trig_passthru),
                  shadow[reg_soft_trig_passthru]);
      check_equal("soft trigger enable", 64'(cfg.soft_trig_enable),
                  shadow[reg_soft_trig_enable]);
      check_equal("capture raw", 64'(cfg.capture_raw), shadow[reg_capture_raw]);
      check_equal("record syncs", 64'(cfg.record_syncs), shadow[reg_record_syncs]);
      check_equal("trace enable", 64'(cfg.trace_en), shadow[reg_trace_en]);
      check_equal("SWO enable", 64'(cfg.swo_enable), shadow[reg_swo_enable]);
      check_equal("bitrate divider", 64'(cfg.swo_bitrate_div), shadow[reg_swo_bitrate_div]);
      check_equal("stop bits", 64'(cfg.uart_stop_bits), shadow[reg_uart_stop_bits]);
      check_equal("data bits", 64'(cfg.uart_data_bits), shadow[reg_uart_data_bits]);
      check_equal("parity_bit", 64'(cfg.uart_parity.fields.parity_bit),
                  64'(shadow[reg_uart_parity][0]));
      check_equal("parity_enabled", 64'(cfg.uart_parity.fields.parity_enabled),
                  64'(shadow[reg_uart_parity][1]));
      check_equal("accept_errors", 64'(cfg.uart_parity.fields.accept_errors),
                  64'(shadow[reg_uart_parity][2]));
   endtask

   // Bit i holds the level at the i-th falling edge
   task automatic sample_pulses(output logic [5:0] rs, output logic [5:0] pl);
      for (int i = 0; i < 6; i++) begin
         @(negedge usb_clk);
         rs[i] = reset_sync;
         pl[i] = phase_load;
      end
   endtask

   task automatic end_test(input string name);
      $display("Test %s finished with %0d errors", name, errors - test_start);
      test_start = errors;
   endtask

   // Read data is stable mid-cycle
   always @(negedge usb_clk) begin : compare_read
      logic [16:0] entry;
      if (exp_q.size() > 0) begin
         entry = exp_q.pop_front();
         checks++;
         if (read_data !== entry[7:0]) begin
            errors++;
            $display("** Error at %0t ns: read of address %0d byte %0d is %h, expected %h",
                     $time, entry[16:11], entry[10:8], read_data, entry[7:0]);
         end
      end
   end

   initial begin : watchdog
      repeat (watchdog_cycles) @(posedge usb_clk);
      $display("Timeout: the tests did not finish within %0d clock cycles", watchdog_cycles);
      $display("Verification failed");
      $finish;
   end

   ////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////

   initial begin : main
      logic [5:0] rs;
      logic [5:0] pl;
      logic [7:0] hi_byte;
      reset_model();
      repeat (5) @(posedge usb_clk);
      #1;
      reset_i = 1'b0;

      // 1: reset values
      check_equal("read_data after reset", 64'(read_data), 64'd0);
      check_equal("reset_sync after reset", 64'(reset_sync), 64'd0);
      check_equal("phase_load after reset", 64'(phase_load), 64'd0);
      verify_range(0, 63);
      check_rules();
      check_cfg();
      end_test("reset values");

      // 2: rule and control writes
      for (int n = 0; n < 2*match_rules; n++) begin
         for (int bc = 0; bc < 8; bc++) begin
            bus_write(select_code, 1'b1, reg_pattern_base + 6'(n), bc, 8'($random(seed)));
         end
      end
      foreach (ctrl_addrs[i]) begin
         bus_write(select_code, 1'b1, ctrl_addrs[i], 0, 8'($random(seed)));
      end
      bus_write(select_code, 1'b1, reg_swo_bitrate_div, 0, 8'($random(seed)));
      bus_write(select_code, 1'b1, reg_swo_bitrate_div, 1, 8'($random(seed)));
      check_rules();
      check_cfg();
      verify_range(0, 63);
      end_test("register writes");

      // 3: wrong select code and address valid low
      for (int a = 0; a < 40; a += 3) begin
         bus_read(2'd1, 1'b1, 6'(a), 0);
         bus_read(select_code, 1'b0, 6'(a), 0);
         bus_write(2'd3, 1'b1, 6'(a), 1, 8'($random(seed)));
         bus_write(select_code, 1'b0, 6'(a), 0, 8'($random(seed)));
      end
      check_rules();
      check_cfg();
      check_equal("phase_requested after unselected writes", 64'(phase_requested),
                  64'(phase_model));
      verify_range(0, 63);
      end_test("unselected access");

      // 4: status and trace counts
      @(posedge usb_clk);
      #1;
      status.synchronized     = 1'($random(seed));
      status.swo_cdc_overflow = 1'($random(seed));
      status.trigger_freq     = $random(seed);
      status.fe_freq          = $random(seed);
      status.phase_locked     = 1'b1;
      trace_counts            = {$random(seed), $random(seed)};
      verify_range(reg_synchronized, reg_trace_count);
      verify_range(reg_traceclk_phase, reg_traceclk_phase);
      end_test("status readback");

      // 5: resync pulse, phase load and phase-done latch
      bus_write(select_code, 1'b1, reg_trace_reset_sync, 0, 8'h01);
      sample_pulses(rs, pl);
      check_equal("reset_sync after resync write", 64'(rs), 64'(6'b000001));
      check_equal("phase_load after resync write", 64'(pl), 64'd0);
      bus_write(select_code, 1'b1, reg_traceclk_phase, 0, 8'($random(seed)));
      sample_pulses(rs, pl);
      check_equal("phase_load after low byte", 64'(pl), 64'd0);
      hi_byte = 8'($random(seed));
      bus_write(select_code, 1'b1, reg_traceclk_phase, 1, hi_byte);
      sample_pulses(rs, pl);
      check_equal("phase_load after high byte", 64'(pl), 64'(6'b000001));
      check_equal("phase_requested", 64'(phase_requested), 64'(phase_model));
      @(posedge usb_clk);
      #1;
      phase_done = 1'b1;
      @(posedge usb_clk);
      #1;
      phase_done = 1'b0;
      done_model = 1'b1;
      bus_read(select_code, 1'b1, reg_traceclk_phase, 0);
      bus_write(select_code, 1'b1, reg_traceclk_phase, 1, hi_byte);
      done_model = 1'b0;                         // Next load clears it
      sample_pulses(rs, pl);
      check_equal("phase_load on reload", 64'(pl), 64'(6'b000001));
      bus_read(select_code, 1'b1, reg_traceclk_phase, 0);
      end_test("pulses and phase latch");

      repeat (2) @(posedge usb_clk);
      if (exp_q.size() != 0) begin
         errors++;
         $display("Some reads were never compared against read_data");
      end
      $display("Summary: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

//--- all.f
source/trace_reg_pkg.sv
source/reg_bus_decode.sv
source/match_rule_regs.sv
source/trace_ctrl_regs.sv
source/reg_read_mux.sv
source/reg_trace.sv
test/tb_reg_trace.sv

//--- Makefile
# Verilator build for the trace sniffer register block

TOOL     = verilator
FLAGS    = --timing --assert
TOP      = tb_reg_trace
FILELIST = all.f
OBJDIR   = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# Pass only when the testbench prints the pass line
sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf $(OBJDIR)
